// File: common/fir_axil_pkg.sv
// register map constants, address type and status bit positions
`default_nettype none

package fir_axil_pkg;

    // **********************************************************
    // address space
    // **********************************************************
    localparam int ADDR_WIDTH = 12;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // **********************************************************
    // register map
    // **********************************************************
    // control and status word
    localparam addr_t CTRL_ADDR     = 12'h000;
    // number of outputs in the run
    localparam addr_t LEN_ADDR      = 12'h010;
    // coefficient h[0]
    localparam addr_t TAP_BASE_ADDR = 12'h020;
    // coefficient h[10]
    localparam addr_t TAP_LAST_ADDR = 12'h048;

    // bit positions inside the status word
    localparam int START_BIT = 0;
    localparam int DONE_BIT  = 1;
    localparam int IDLE_BIT  = 2;

    // read data for any address outside the map
    localparam logic [31:0] UNMAPPED_VALUE = 32'hffff_ffff;

endpackage

`default_nettype wire

// File: common/fir_dsp_pkg.sv
// datapath widths, sample and tap index types, MAC engine states
`default_nettype none

package fir_dsp_pkg;

    // samples, coefficients and results share one width
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // **********************************************************
    // filter length
    // **********************************************************
    localparam int NUM_TAPS      = 11;
    localparam int TAP_IDX_WIDTH = $clog2(NUM_TAPS);

    // 0 .. NUM_TAPS-1
    typedef logic [TAP_IDX_WIDTH-1:0] tap_idx_t;

    // index of the oldest tap
    localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

    // MAC engine FSM
    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_RUN,
        MAC_HOLD
    } mac_state_t;

endpackage

`default_nettype wire

// File: design/fir_ctrl_regs.sv
// AXI-Lite register block with run status, output countdown and coefficients
`timescale 1ns/10ps
`default_nettype none

module fir_ctrl_regs
(
    input  wire logic                  axis_clk,
    input  wire logic                  axis_rst_n,

    input  wire logic                  awvalid,
    input  wire fir_axil_pkg::addr_t   awaddr,
    output      logic                  awready,
    input  wire logic                  wvalid,
    input  wire fir_dsp_pkg::data_t    wdata,
    output      logic                  wready,

    input  wire logic                  arvalid,
    input  wire fir_axil_pkg::addr_t   araddr,
    output      logic                  arready,
    output      logic                  rvalid,
    input  wire logic                  rready,
    output      fir_dsp_pkg::data_t    rdata,

    output      logic                  run_active,
    output      logic                  run_start,
    output      logic                  last_pending,
    input  wire fir_dsp_pkg::tap_idx_t tap_index,
    output      fir_dsp_pkg::data_t    tap_coef,
    input  wire logic                  out_fire
);

    // address lies on one of the coefficient words
    function automatic logic tap_hit(fir_axil_pkg::addr_t addr);
        return (addr >= fir_axil_pkg::TAP_BASE_ADDR) &&
               (addr <= fir_axil_pkg::TAP_LAST_ADDR) &&
               (addr[1:0] == 2'b00);
    endfunction

    // word offset from the first coefficient
    function automatic fir_dsp_pkg::tap_idx_t tap_sel(fir_axil_pkg::addr_t addr);
        fir_axil_pkg::addr_t offset;
        offset = addr - fir_axil_pkg::TAP_BASE_ADDR;
        return fir_dsp_pkg::tap_idx_t'(offset >> 2);
    endfunction

    logic               ap_start;
    logic               ap_done;
    logic               ap_idle;
    // also the count of outputs still to come
    fir_dsp_pkg::data_t data_length;
    fir_dsp_pkg::data_t coef [fir_dsp_pkg::NUM_TAPS];
    fir_dsp_pkg::data_t status_word;

    logic wr_fire;
    logic ctrl_wr;
    logic len_wr;
    logic rd_fire;
    logic run_close;

    // **********************************************************
    // write channel
    // **********************************************************
    // address and data are taken together in one cycle
    assign wr_fire = awvalid & wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // start only accepted while idle
    assign ctrl_wr   = wr_fire & (awaddr == fir_axil_pkg::CTRL_ADDR) & ap_idle;
    assign len_wr    = wr_fire & (awaddr == fir_axil_pkg::LEN_ADDR);
    assign run_start = ctrl_wr & wdata[fir_axil_pkg::START_BIT];

    assign run_active   = ~ap_idle;
    assign last_pending = (data_length == fir_dsp_pkg::data_t'(1));
    // transfer of the tlast output ends the run
    assign run_close    = out_fire & last_pending;

    // read address taken whenever no response is pending
    assign arready = ~rvalid;
    assign rd_fire = arvalid & arready;

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            ap_start    <= 1'b0;
            ap_done     <= 1'b0;
            ap_idle     <= 1'b1;
            data_length <= '0;
            rvalid      <= 1'b0;
        end
        else
        begin
            if (ctrl_wr)
                ap_start <= wdata[fir_axil_pkg::START_BIT];
            if (run_start)
                ap_idle <= 1'b0;
            // reading the status word clears done
            if (rd_fire && (araddr == fir_axil_pkg::CTRL_ADDR))
                ap_done <= 1'b0;

            // countdown, one per output transfer
            if (len_wr)
                data_length <= wdata;
            else if (out_fire)
                data_length <= data_length - 1'b1;

            if (run_close)
            begin
                ap_start <= 1'b0;
                ap_done  <= 1'b1;
                ap_idle  <= 1'b1;
            end

            // response held until rready
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // **********************************************************
    // coefficient registers
    // **********************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
                coef[i] <= '0;
        end
        else if (wr_fire && tap_hit(awaddr))
        begin
            coef[tap_sel(awaddr)] <= wdata;
        end
    end

    // operand for the MAC engine
    assign tap_coef = coef[tap_index];

    // **********************************************************
    // read data
    // **********************************************************
    always_comb
    begin
        status_word                           = '0;
        status_word[fir_axil_pkg::START_BIT] = ap_start;
        status_word[fir_axil_pkg::DONE_BIT]  = ap_done;
        status_word[fir_axil_pkg::IDLE_BIT]  = ap_idle;
    end

    // captured with the address, stable while rvalid
    always_ff @(posedge axis_clk)
    begin
        if (rd_fire)
        begin
            if (araddr == fir_axil_pkg::CTRL_ADDR)
                rdata <= status_word;
            else if (araddr == fir_axil_pkg::LEN_ADDR)
                rdata <= data_length;
            else if (tap_hit(araddr))
                rdata <= coef[tap_sel(araddr)];
            else
                rdata <= fir_axil_pkg::UNMAPPED_VALUE;
        end
    end

endmodule

`default_nettype wire

// File: fir_core/fir_sample_window.sv
// stream input acceptance and circular history of the last 11 samples
`timescale 1ns/10ps
`default_nettype none

module fir_sample_window
(
    input  wire logic                  axis_clk,
    input  wire logic                  axis_rst_n,

    input  wire logic                  ss_tvalid,
    input  wire fir_dsp_pkg::data_t    ss_tdata,
    output      logic                  ss_tready,

    input  wire logic                  run_active,
    input  wire logic                  run_start,
    input  wire logic                  engine_ready,

    input  wire fir_dsp_pkg::tap_idx_t tap_index,
    output      logic                  sample_taken,
    output      fir_dsp_pkg::data_t    window_sample
);

    // one extra bit for the wrap sum
    typedef logic [fir_dsp_pkg::TAP_IDX_WIDTH:0] wrap_sum_t;

    fir_dsp_pkg::data_t    hist [fir_dsp_pkg::NUM_TAPS];
    // next slot to write
    fir_dsp_pkg::tap_idx_t head;
    wrap_sum_t             rd_sum;
    fir_dsp_pkg::tap_idx_t rd_ptr;

    // **********************************************************
    // input handshake
    // **********************************************************
    // engine must be idle, so a busy MAC stalls the stream
    assign ss_tready    = run_active & engine_ready;
    assign sample_taken = ss_tvalid & ss_tready;

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            head <= '0;
            for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
                hist[i] <= '0;
        end
        else if (run_start)
        begin
            // samples before the run read as zero
            head <= '0;
            for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
                hist[i] <= '0;
        end
        else if (sample_taken)
        begin
            hist[head] <= ss_tdata;
            if (head == fir_dsp_pkg::LAST_TAP)
                head <= '0;
            else
                head <= head + 1'b1;
        end
    end

    // **********************************************************
    // history read
    // **********************************************************
    // newest sample sits at head-1, tap k is k slots further back
    always_comb
    begin
        rd_sum = wrap_sum_t'(head) + wrap_sum_t'(fir_dsp_pkg::LAST_TAP)
                 - wrap_sum_t'(tap_index);
        if (rd_sum >= wrap_sum_t'(fir_dsp_pkg::NUM_TAPS))
            rd_ptr = fir_dsp_pkg::tap_idx_t'(rd_sum - wrap_sum_t'(fir_dsp_pkg::NUM_TAPS));
        else
            rd_ptr = fir_dsp_pkg::tap_idx_t'(rd_sum);
    end

    assign window_sample = hist[rd_ptr];

endmodule

`default_nettype wire

// File: fir_core/fir_mac_engine.sv
// tap sequencer, multiply-accumulate, output register and stream output handshake
`timescale 1ns/10ps
`default_nettype none

module fir_mac_engine
(
    input  wire logic                  axis_clk,
    input  wire logic                  axis_rst_n,

    input  wire logic                  sample_taken,
    output      logic                  engine_ready,
    output      fir_dsp_pkg::tap_idx_t tap_index,
    input  wire fir_dsp_pkg::data_t    tap_coef,
    input  wire fir_dsp_pkg::data_t    window_sample,

    input  wire logic                  last_pending,
    input  wire logic                  sm_tready,
    output      logic                  sm_tvalid,
    output      logic                  sm_tlast,
    output      fir_dsp_pkg::data_t    sm_tdata,
    output      logic                  out_fire
);

    fir_dsp_pkg::mac_state_t state;
    fir_dsp_pkg::data_t      acc;
    fir_dsp_pkg::data_t      product;
    logic                    start_mac;
    logic                    last_tap;
    logic                    load_out;

    assign engine_ready = (state == fir_dsp_pkg::MAC_IDLE);
    assign start_mac    = engine_ready & sample_taken;
    assign last_tap     = (tap_index == fir_dsp_pkg::LAST_TAP);
    // sum waits until the output register is empty
    assign load_out     = (state == fir_dsp_pkg::MAC_HOLD) & ~sm_tvalid;
    assign out_fire     = sm_tvalid & sm_tready;

    // low 32 bits only, wrap-around arithmetic
    assign product = tap_coef * window_sample;

    // **********************************************************
    // FSM and tap sequencer
    // **********************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            state     <= fir_dsp_pkg::MAC_IDLE;
            tap_index <= '0;
        end
        else
        begin
            case (state)
                fir_dsp_pkg::MAC_IDLE:
                begin
                    tap_index <= '0;
                    if (start_mac)
                        state <= fir_dsp_pkg::MAC_RUN;
                end
                fir_dsp_pkg::MAC_RUN:
                begin
                    // one tap per cycle, newest sample first
                    if (last_tap)
                    begin
                        tap_index <= '0;
                        state     <= fir_dsp_pkg::MAC_HOLD;
                    end
                    else
                    begin
                        tap_index <= tap_index + 1'b1;
                    end
                end
                fir_dsp_pkg::MAC_HOLD:
                begin
                    if (load_out)
                        state <= fir_dsp_pkg::MAC_IDLE;
                end
                default:
                begin
                    state <= fir_dsp_pkg::MAC_IDLE;
                end
            endcase
        end
    end

    // accumulator, cleared as each sample arrives
    always_ff @(posedge axis_clk)
    begin
        if (start_mac)
            acc <= '0;
        else if (state == fir_dsp_pkg::MAC_RUN)
            acc <= acc + product;
    end

    // **********************************************************
    // output register
    // **********************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
        else if (load_out)
        begin
            sm_tvalid <= 1'b1;
            // this result is the final one of the run
            sm_tlast  <= last_pending;
        end
        else if (out_fire)
        begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    // result held until sm_tready
    always_ff @(posedge axis_clk)
    begin
        if (load_out)
            sm_tdata <= acc;
    end

endmodule

`default_nettype wire

// File: design/fir_top.sv
// FIR top level joining register block, sample window and MAC engine
`timescale 1ns/10ps
`default_nettype none

module fir_top
(
    input  wire logic                  axis_clk,
    input  wire logic                  axis_rst_n,

    // AXI-Lite write
    input  wire logic                  awvalid,
    input  wire fir_axil_pkg::addr_t   awaddr,
    output      logic                  awready,
    input  wire logic                  wvalid,
    input  wire fir_dsp_pkg::data_t    wdata,
    output      logic                  wready,

    // AXI-Lite read
    input  wire logic                  arvalid,
    input  wire fir_axil_pkg::addr_t   araddr,
    output      logic                  arready,
    output      logic                  rvalid,
    input  wire logic                  rready,
    output      fir_dsp_pkg::data_t    rdata,

    // AXI-Stream in
    input  wire logic                  ss_tvalid,
    input  wire fir_dsp_pkg::data_t    ss_tdata,
    // run length comes from LEN_ADDR, input tlast is not used
    input  wire logic                  ss_tlast,
    output      logic                  ss_tready,

    // AXI-Stream out
    input  wire logic                  sm_tready,
    output      logic                  sm_tvalid,
    output      fir_dsp_pkg::data_t    sm_tdata,
    output      logic                  sm_tlast
);

    // run control from the register block
    logic                  run_active;
    logic                  run_start;
    logic                  last_pending;

    // tap select and the two operands it picks
    fir_dsp_pkg::tap_idx_t tap_index;
    fir_dsp_pkg::data_t    tap_coef;
    fir_dsp_pkg::data_t    window_sample;

    // handshakes between window and engine
    logic                  sample_taken;
    logic                  engine_ready;
    logic                  out_fire;

    // **********************************************************
    // register block, holds config and coefficients
    // **********************************************************
    fir_ctrl_regs u_ctrl_regs
    (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wready       (wready),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .run_active   (run_active),
        .run_start    (run_start),
        .last_pending (last_pending),
        .tap_index    (tap_index),
        .tap_coef     (tap_coef),
        .out_fire     (out_fire)
    );

    // input side, sample history
    fir_sample_window u_sample_window
    (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .ss_tvalid     (ss_tvalid),
        .ss_tdata      (ss_tdata),
        .ss_tready     (ss_tready),
        .run_active    (run_active),
        .run_start     (run_start),
        .engine_ready  (engine_ready),
        .tap_index     (tap_index),
        .sample_taken  (sample_taken),
        .window_sample (window_sample)
    );

    // output side, multiply-accumulate
    fir_mac_engine u_mac_engine
    (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .sample_taken  (sample_taken),
        .engine_ready  (engine_ready),
        .tap_index     (tap_index),
        .tap_coef      (tap_coef),
        .window_sample (window_sample),
        .last_pending  (last_pending),
        .sm_tready     (sm_tready),
        .sm_tvalid     (sm_tvalid),
        .sm_tlast      (sm_tlast),
        .sm_tdata      (sm_tdata),
        .out_fire      (out_fire)
    );

endmodule

`default_nettype wire

// File: test/fir_tb.sv
// FIR testbench with clock, reset, reference model, directed tests and timeout
`timescale 1ns/10ps
`default_nettype none

module fir_tb;

    // far above the length of all tests together
    localparam int TIMEOUT_CYCLES = 20000;

    logic                axis_clk;
    logic                axis_rst_n;
    logic                awvalid;
    logic                wvalid;
    logic                arvalid;
    logic                rready;
    fir_axil_pkg::addr_t awaddr;
    fir_axil_pkg::addr_t araddr;
    fir_dsp_pkg::data_t  wdata;
    logic                awready;
    logic                wready;
    logic                arready;
    logic                rvalid;
    fir_dsp_pkg::data_t  rdata;
    logic                ss_tvalid;
    logic                ss_tlast;
    fir_dsp_pkg::data_t  ss_tdata;
    logic                ss_tready;
    logic                sm_tready;
    logic                sm_tvalid;
    logic                sm_tlast;
    fir_dsp_pkg::data_t  sm_tdata;

    // model state and captured stream
    fir_dsp_pkg::data_t  taps_model [fir_dsp_pkg::NUM_TAPS];
    fir_dsp_pkg::data_t  tx_samples [$];
    fir_dsp_pkg::data_t  rx_data [$];
    logic                rx_last [$];

    int error_count = 0;
    int tests_run   = 0;
    int tests_bad   = 0;
    int cycle_count = 0;

    fir_top DUT
    (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    initial
    begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    // run guard
    always @(posedge axis_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, DUT stopped responding", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ************************************************************
    // bus helpers
    // ************************************************************
    task automatic check_value(input string name, input fir_dsp_pkg::data_t expected,
                               input fir_dsp_pkg::data_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // address and data offered together
    task automatic write_reg(input fir_axil_pkg::addr_t addr, input fir_dsp_pkg::data_t data);
        @(posedge axis_clk);
        #2;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge axis_clk);
        if (!(awready && wready))
        begin
            error_count++;
            $display("write to %h was not accepted in the valid cycle", addr);
        end
        @(posedge axis_clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input fir_axil_pkg::addr_t addr, output fir_dsp_pkg::data_t data);
        @(posedge axis_clk);
        #2;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        do @(negedge axis_clk); while (!arready);
        @(posedge axis_clk);
        #2;
        arvalid = 1'b0;
        do @(negedge axis_clk); while (!rvalid);
        data = rdata;
        @(posedge axis_clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic write_taps();
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
            write_reg(fir_axil_pkg::addr_t'(fir_axil_pkg::TAP_BASE_ADDR + 4 * i), taps_model[i]);
    endtask

    // ************************************************************
    // stream side and reference model
    // ************************************************************
    // y[n] = sum of h[i] x[n-i] over a zero history with 32-bit wrap
    function automatic fir_dsp_pkg::data_t model_output(int n);
        fir_dsp_pkg::data_t acc;
        acc = '0;
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
            if (n - i >= 0)
                acc = acc + taps_model[i] * tx_samples[n - i];
        return acc;
    endfunction

    task automatic send_samples();
        for (int n = 0; n < tx_samples.size(); n++)
        begin
            @(posedge axis_clk);
            #2;
            ss_tvalid = 1'b1;
            ss_tdata  = tx_samples[n];
            // transfer happens at the edge after ready is seen
            do @(negedge axis_clk); while (!ss_tready);
        end
        @(posedge axis_clk);
        #2;
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int count, input bit rand_ready);
        while (rx_data.size() < count)
        begin
            @(posedge axis_clk);
            #2;
            // sparse ready keeps results waiting long enough to stall the engine
            sm_tready = rand_ready ? (($urandom & 32'hf) == 0) : 1'b1;
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready)
            begin
                rx_data.push_back(sm_tdata);
                rx_last.push_back(sm_tlast);
            end
        end
        @(posedge axis_clk);
        #2;
        sm_tready = 1'b0;
    endtask

    task automatic start_run(input int count);
        write_reg(fir_axil_pkg::LEN_ADDR, fir_dsp_pkg::data_t'(count));
        write_reg(fir_axil_pkg::CTRL_ADDR, 32'h1);
    endtask

    task automatic stream_run(input int count, input bit rand_ready);
        rx_data.delete();
        rx_last.delete();
        fork
            send_samples();
            collect_outputs(count, rand_ready);
        join
    endtask

    // model data in order and tlast on the final output only
    task automatic check_outputs(input string name, input int count);
        for (int n = 0; n < count; n++)
        begin
            check_value(name, model_output(n), rx_data[n]);
            check_value(name, fir_dsp_pkg::data_t'(n == count - 1),
                        fir_dsp_pkg::data_t'(rx_last[n]));
        end
        repeat (4) @(negedge axis_clk);
        if (sm_tvalid)
        begin
            error_count++;
            $display("%s saw an extra output after the run ended", name);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("test %s passed", name);
        else
        begin
            tests_bad++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic test_reset_state();
        fir_dsp_pkg::data_t value;
        int                 errors_before;
        errors_before = error_count;
        @(negedge axis_clk);
        if (!arready || rvalid || awready || wready || ss_tready || sm_tvalid || sm_tlast)
        begin
            error_count++;
            $display("reset_state found handshake outputs not at their reset values");
        end
        read_reg(fir_axil_pkg::CTRL_ADDR, value);
        check_value("reset_state", 32'h4, value);
        read_reg(12'h004, value);
        check_value("reset_state", 32'hffff_ffff, value);
        finish_test("reset_state", errors_before);
    endtask

    task automatic test_readback();
        fir_dsp_pkg::data_t value;
        fir_dsp_pkg::data_t len_value;
        int                 errors_before;
        errors_before = error_count;
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
            taps_model[i] = $urandom;
        len_value = $urandom;
        write_taps();
        write_reg(fir_axil_pkg::LEN_ADDR, len_value);
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
        begin
            read_reg(fir_axil_pkg::addr_t'(fir_axil_pkg::TAP_BASE_ADDR + 4 * i), value);
            check_value("readback", taps_model[i], value);
        end
        read_reg(fir_axil_pkg::LEN_ADDR, value);
        check_value("readback", len_value, value);
        finish_test("readback", errors_before);
    endtask

    task automatic test_impulse();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
            taps_model[i] = fir_dsp_pkg::data_t'(i + 1);
        write_taps();
        tx_samples.delete();
        tx_samples.push_back(32'h1);
        repeat (10) tx_samples.push_back(32'h0);
        start_run(11);
        stream_run(11, 1'b0);
        // impulse response is the tap list itself
        for (int n = 0; n < rx_data.size(); n++)
            check_value("impulse", fir_dsp_pkg::data_t'(n + 1), rx_data[n]);
        check_outputs("impulse", 11);
        finish_test("impulse", errors_before);
    endtask

    task automatic test_random_run();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < fir_dsp_pkg::NUM_TAPS; i++)
            taps_model[i] = $urandom;
        write_taps();
        tx_samples.delete();
        repeat (30) tx_samples.push_back($urandom);
        start_run(30);
        stream_run(30, 1'b1);
        check_outputs("random_run", 30);
        finish_test("random_run", errors_before);
    endtask

    task automatic test_status();
        fir_dsp_pkg::data_t value;
        int                 errors_before;
        errors_before = error_count;
        tx_samples.delete();
        repeat (4) tx_samples.push_back($urandom);
        start_run(4);
        // done may still be set from the previous run
        read_reg(fir_axil_pkg::CTRL_ADDR, value);
        check_value("status", 32'h1, value & 32'h5);
        stream_run(4, 1'b0);
        check_outputs("status", 4);
        read_reg(fir_axil_pkg::CTRL_ADDR, value);
        check_value("status", 32'h6, value);
        // first read cleared done
        read_reg(fir_axil_pkg::CTRL_ADDR, value);
        check_value("status", 32'h4, value);
        finish_test("status", errors_before);
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************
    initial
    begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        awaddr     = '0;
        araddr     = '0;
        wdata      = '0;
        ss_tvalid  = 1'b0;
        ss_tlast   = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        void'($urandom(32'hf3c7));
        repeat (3) @(posedge axis_clk);
        #2;
        axis_rst_n = 1'b1;

        test_reset_state();
        test_readback();
        test_impulse();
        test_random_run();
        test_status();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_bad, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/fir_axil_pkg.sv
common/fir_dsp_pkg.sv
design/fir_ctrl_regs.sv
fir_core/fir_sample_window.sv
fir_core/fir_mac_engine.sv
design/fir_top.sv
test/fir_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the FIR testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module fir_tb -o fir_sim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/fir_sim > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; } \
    || echo "simulation finished without failure"
